/* common/dcache_pkg.sv */
package dcache_pkg;

        // 2-way, 256 sets, 16-byte lines
        localparam int index_bits = 8;
        localparam int tag_bits = 20;
        localparam int offset_bits = 4;
        localparam int num_banks = 4;
        localparam int num_ways = 2;
        localparam logic [2:0] burst_type = 3'b100;     // full line on the bridge

        typedef logic [index_bits-1:0] index_t;
        typedef logic [tag_bits-1:0] tag_t;
        typedef logic [offset_bits-1:0] offset_t;
        typedef logic [$clog2(num_banks)-1:0] bank_t;
        typedef logic [31:0] word_t;
        typedef logic [3:0] strb_t;
        typedef logic [num_banks*32-1:0] line_t;
        typedef logic [31:0] addr_t;

        typedef enum logic [2:0] {idle, lookup, miss, replace, refill} main_state_t;
        typedef enum logic {wbuf_idle, wbuf_write} wbuf_state_t;

endpackage

/* rtl/sync_ram.sv */
`timescale 1ns/1ns
module sync_ram #(
        parameter int width = 32,
        parameter int depth = 256,
        parameter int lanes = 4
) (
        input  logic                     clk,
        input  logic                     en,
        input  logic [lanes-1:0]         we,
        input  logic [$clog2(depth)-1:0] addr,
        input  logic [width-1:0]         din,
        output logic [width-1:0]         dout
);
        localparam int lane_w = width / lanes;

        logic [width-1:0] mem [depth];

        initial begin
                for (int i = 0; i < depth; i++)
                        mem[i] = '0;    // valid bits start clear
        end

        always_ff @(posedge clk) begin
                if (en) begin
                        for (int l = 0; l < lanes; l++) begin
                                if (we[l])
                                        mem[addr][l*lane_w +: lane_w] <= din[l*lane_w +: lane_w];
                        end
                        if (we == '0)
                                dout <= mem[addr];      // output holds across writes
                end
        end

endmodule

/* dcache/dcache_ctrl.sv */
`timescale 1ns/1ns
module dcache_ctrl (
        input  logic                    clk,
        input  logic                    resetn,
        input  logic                    valid,
        input  logic                    op,
        input  dcache_pkg::index_t      index,
        input  dcache_pkg::tag_t        tag,
        input  dcache_pkg::offset_t     offset,
        input  dcache_pkg::strb_t       wstrb,
        input  dcache_pkg::word_t       wdata,
        input  logic                    cache_hit,
        input  logic [1:0]              way_hit,
        input  logic                    victim_dirty,
        input  logic                    rd_rdy,
        input  logic                    wr_rdy,
        input  logic                    ret_valid,
        input  logic                    ret_last,
        input  dcache_pkg::bank_t       refill_bank,
        output dcache_pkg::main_state_t state,
        output logic                    req_op,
        output dcache_pkg::index_t      req_index,
        output dcache_pkg::tag_t        req_tag,
        output dcache_pkg::offset_t     req_offset,
        output dcache_pkg::strb_t       req_wstrb,
        output dcache_pkg::word_t       req_wdata,
        output logic                    check,
        output logic                    wb_valid,
        output logic                    wb_way,
        output dcache_pkg::bank_t       wb_bank,
        output dcache_pkg::index_t      wb_index,
        output dcache_pkg::strb_t       wb_strb,
        output dcache_pkg::word_t       wb_data,
        output logic                    addr_ok,
        output logic                    data_ok
);
        import dcache_pkg::*;

        main_state_t next_state;
        wbuf_state_t wbuf_state;
        logic hit_store;
        logic need_pause;
        logic victim_rd;        // victim line re-read has landed

        assign hit_store = (state == lookup) && req_op && cache_hit;
        assign wb_valid = (wbuf_state == wbuf_write);

        // read vs. buffered store, or vs. store still in lookup (raw)
        assign need_pause = valid && !op &&
                ((wb_valid && offset[3:2] == wb_bank) ||
                 (hit_store && index == req_index && offset[3:2] == req_offset[3:2]));

        assign addr_ok = !need_pause &&
                ((state == idle) || ((state == lookup) && cache_hit && valid));
        assign check = valid && addr_ok;

        always_comb begin
                next_state = state;
                case (state)
                        idle: begin
                                if (check)
                                        next_state = lookup;
                        end
                        lookup: begin
                                if (!cache_hit)
                                        next_state = miss;
                                else if (!check)
                                        next_state = idle;
                        end
                        miss: begin
                                if (victim_rd && (!victim_dirty || wr_rdy))
                                        next_state = replace;
                        end
                        replace: begin
                                if (rd_rdy)
                                        next_state = refill;
                        end
                        refill: begin
                                if (ret_valid && ret_last)
                                        next_state = idle;
                        end
                        default: next_state = idle;
                endcase
        end

        always_ff @(posedge clk) begin
                if (!resetn) begin
                        state <= idle;
                        wbuf_state <= wbuf_idle;
                        victim_rd <= 1'b0;
                end else begin
                        state <= next_state;
                        wbuf_state <= hit_store ? wbuf_write : wbuf_idle;
                        victim_rd <= (state == miss);
                end
        end

        always_ff @(posedge clk) begin
                if (check) begin
                        req_op <= op;
                        req_index <= index;
                        req_tag <= tag;
                        req_offset <= offset;
                        req_wstrb <= wstrb;
                        req_wdata <= wdata;
                end
                if (hit_store) begin    // commit goes out next cycle
                        wb_way <= way_hit[1];
                        wb_bank <= req_offset[3:2];
                        wb_index <= req_index;
                        wb_strb <= req_wstrb;
                        wb_data <= req_wdata;
                end
        end

        // stores answer from lookup, read misses on their own refill beat
        assign data_ok = ((state == lookup) && (cache_hit || req_op)) ||
                ((state == refill) && ret_valid && !req_op &&
                 refill_bank == req_offset[3:2]);

endmodule

/* dcache/dcache_arrays.sv */
`timescale 1ns/1ns
module dcache_arrays (
        input  logic                    clk,
        input  logic                    resetn,
        input  dcache_pkg::main_state_t state,
        input  logic                    check,
        input  dcache_pkg::index_t      index,
        input  dcache_pkg::offset_t     offset,
        input  dcache_pkg::index_t      req_index,
        input  dcache_pkg::tag_t        req_tag,
        input  dcache_pkg::offset_t     req_offset,
        input  logic                    req_op,
        input  logic                    wb_valid,
        input  logic                    wb_way,
        input  dcache_pkg::bank_t       wb_bank,
        input  dcache_pkg::index_t      wb_index,
        input  dcache_pkg::strb_t       wb_strb,
        input  dcache_pkg::word_t       wb_data,
        input  logic                    ret_valid,
        input  dcache_pkg::bank_t       refill_bank,
        input  dcache_pkg::word_t       refill_word,
        input  logic                    victim_way,
        output logic [1:0]              way_hit,
        output logic                    cache_hit,
        output logic                    victim_dirty,
        output dcache_pkg::tag_t        victim_tag,
        output dcache_pkg::word_t       hit_word,
        output dcache_pkg::line_t       victim_line
);
        import dcache_pkg::*;

        logic [tag_bits:0] tagv_dout [num_ways];
        word_t bank_dout [num_ways][num_banks];
        line_t way_line [num_ways];
        logic [(1 << index_bits)-1:0] dirty [num_ways];
        index_t bank_addr [num_banks];
        word_t bank_din;
        logic refill_wr;

        assign refill_wr = (state == refill) && ret_valid;
        assign bank_din = refill_wr ? refill_word : wb_data;

        for (genvar b = 0; b < num_banks; b++) begin : g_addr
                // committing bank follows the buffer, the rest the lookup
                assign bank_addr[b] = (wb_valid && wb_bank == b) ? wb_index :
                                      check ? index : req_index;
        end

        for (genvar w = 0; w < num_ways; w++) begin : g_way
                logic tag_we;

                assign tag_we = refill_wr && victim_way == w;

                sync_ram #(.width(tag_bits + 1), .depth(1 << index_bits), .lanes(1)) u_tagv (
                        .clk(clk),
                        .en(check || tag_we),
                        .we(tag_we),
                        .addr(check ? index : req_index),
                        .din({req_tag, 1'b1}),
                        .dout(tagv_dout[w])
                );
                assign way_hit[w] = tagv_dout[w][0] && tagv_dout[w][tag_bits:1] == req_tag;

                for (genvar b = 0; b < num_banks; b++) begin : g_bank
                        logic wb_we;
                        logic rf_we;

                        assign wb_we = wb_valid && wb_way == w && wb_bank == b;
                        assign rf_we = refill_wr && victim_way == w && refill_bank == b;

                        // miss re-reads the whole line for write-back
                        sync_ram #(.width(32), .depth(1 << index_bits), .lanes(4)) u_bank (
                                .clk(clk),
                                .en((check && offset[3:2] == b) || state == miss || wb_we || rf_we),
                                .we({4{rf_we}} | ({4{wb_we}} & wb_strb)),
                                .addr(bank_addr[b]),
                                .din(bank_din),
                                .dout(bank_dout[w][b])
                        );
                        assign way_line[w][b*32 +: 32] = bank_dout[w][b];
                end
        end

        always_ff @(posedge clk) begin
                if (!resetn) begin
                        for (int w = 0; w < num_ways; w++)
                                dirty[w] <= '0;
                end else if (wb_valid) begin
                        dirty[wb_way][wb_index] <= 1'b1;
                end else if (refill_wr) begin
                        dirty[victim_way][req_index] <= req_op;    // write miss lands dirty
                end
        end

        assign cache_hit = |way_hit;
        assign hit_word = refill_wr ? refill_word :
                          way_hit[1] ? bank_dout[1][req_offset[3:2]] : bank_dout[0][req_offset[3:2]];

        assign victim_tag = tagv_dout[victim_way][tag_bits:1];
        assign victim_line = way_line[victim_way];
        assign victim_dirty = dirty[victim_way][req_index] && tagv_dout[victim_way][0];

endmodule

/* dcache/dcache_mem_port.sv */
`timescale 1ns/1ns
module dcache_mem_port #(
        parameter logic [7:0] lfsr_seed = 8'h5a
) (
        input  logic                    clk,
        input  logic                    resetn,
        input  dcache_pkg::main_state_t state,
        input  logic                    req_op,
        input  dcache_pkg::index_t      req_index,
        input  dcache_pkg::tag_t        req_tag,
        input  dcache_pkg::offset_t     req_offset,
        input  dcache_pkg::strb_t       req_wstrb,
        input  dcache_pkg::word_t       req_wdata,
        input  logic                    victim_dirty,
        input  dcache_pkg::tag_t        victim_tag,
        input  dcache_pkg::line_t       victim_line,
        input  logic                    ret_valid,
        input  logic                    ret_last,
        input  dcache_pkg::word_t       ret_data,
        output dcache_pkg::bank_t       refill_bank,
        output dcache_pkg::word_t       refill_word,
        output logic                    victim_way,
        output logic                    rd_req,
        output logic [2:0]              rd_type,
        output dcache_pkg::addr_t       rd_addr,
        output logic                    wr_req,
        output logic [2:0]              wr_type,
        output dcache_pkg::addr_t       wr_addr,
        output dcache_pkg::strb_t       wr_wstrb,
        output dcache_pkg::line_t       wr_data
);
        import dcache_pkg::*;

        logic [7:0] lfsr;
        logic victim_rd;
        word_t merged;

        always_ff @(posedge clk) begin
                if (!resetn) begin
                        refill_bank <= '0;
                        lfsr <= lfsr_seed;
                        victim_rd <= 1'b0;
                end else begin
                        if (ret_valid)
                                refill_bank <= ret_last ? '0 : refill_bank + 1'b1;
                        if (state == lookup)    // x^8+x^6+x^5+x^4+1
                                lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
                        victim_rd <= (state == miss);
                end
        end

        always_comb begin
                merged = ret_data;
                for (int i = 0; i < $bits(strb_t); i++) begin
                        if (req_wstrb[i])
                                merged[i*8 +: 8] = req_wdata[i*8 +: 8];
                end
        end

        assign refill_word = (req_op && refill_bank == req_offset[3:2]) ? merged : ret_data;
        assign victim_way = lfsr[0];

        assign rd_req = (state == replace);
        assign rd_type = burst_type;
        assign rd_addr = {req_tag, req_index, 4'b0000};

        // held off one cycle until the re-read victim line is valid
        assign wr_req = (state == miss) && victim_rd && victim_dirty;
        assign wr_type = burst_type;
        assign wr_addr = {victim_tag, req_index, 4'b0000};
        assign wr_wstrb = '1;
        assign wr_data = victim_line;

endmodule

/* dcache/dcache_top.sv */
`timescale 1ns/1ns
module dcache_top #(
        parameter logic [7:0] lfsr_seed = 8'h5a
) (
        input  logic                    clk,
        input  logic                    resetn,
        // cpu side
        input  logic                    valid,
        input  logic                    op,
        input  dcache_pkg::index_t      index,
        input  dcache_pkg::tag_t        tag,
        input  dcache_pkg::offset_t     offset,
        input  dcache_pkg::strb_t       wstrb,
        input  dcache_pkg::word_t       wdata,
        output logic                    addr_ok,
        output logic                    data_ok,
        output dcache_pkg::word_t       rdata,
        // bridge side
        output logic                    rd_req,
        output logic [2:0]              rd_type,
        output dcache_pkg::addr_t       rd_addr,
        input  logic                    rd_rdy,
        input  logic                    ret_valid,
        input  logic                    ret_last,
        input  dcache_pkg::word_t       ret_data,
        output logic                    wr_req,
        output logic [2:0]              wr_type,
        output dcache_pkg::addr_t       wr_addr,
        output dcache_pkg::strb_t       wr_wstrb,
        output dcache_pkg::line_t       wr_data,
        input  logic                    wr_rdy
);
        import dcache_pkg::*;

        main_state_t state;
        logic req_op;
        index_t req_index;
        tag_t req_tag;
        offset_t req_offset;
        strb_t req_wstrb;
        word_t req_wdata;
        logic check;
        logic wb_valid;
        logic wb_way;
        bank_t wb_bank;
        index_t wb_index;
        strb_t wb_strb;
        word_t wb_data;
        logic [1:0] way_hit;
        logic cache_hit;
        logic victim_dirty;
        tag_t victim_tag;
        line_t victim_line;
        bank_t refill_bank;
        word_t refill_word;
        logic victim_way;

        dcache_ctrl u_ctrl (.*);

        dcache_arrays u_arrays (
                .hit_word(rdata),
                .*
        );

        dcache_mem_port #(.lfsr_seed(lfsr_seed)) u_mem_port (.*);

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ns
module tb_clock #(
        parameter int period = 100,
        parameter int reset_cycles = 16
) (
        output logic clk,
        output logic resetn
);

        initial begin
                clk = 1'b0;
                forever #(period / 2) clk = ~clk;
        end

        initial begin
                resetn = 1'b0;
                repeat (reset_cycles) @(posedge clk);
                #10 resetn = 1'b1;      // let go just after an edge
        end

endmodule

/* sim/dcache_assertions.sv */
`timescale 1ns/1ns
module dcache_assertions (
        input  logic                    clk,
        input  logic                    resetn,
        input  dcache_pkg::main_state_t state,
        input  logic                    rd_req,
        input  dcache_pkg::addr_t       rd_addr,
        input  logic                    rd_rdy,
        input  logic                    wr_req,
        input  dcache_pkg::addr_t       wr_addr,
        input  logic                    wr_rdy,
        input  logic                    data_ok
);
        import dcache_pkg::*;

        int failures = 0;       // failed properties so far

        quiet_after_reset: assert property (@(posedge clk) !resetn |=> !rd_req && !wr_req)
                else begin
                        failures++;
                        $error("bridge request high right after reset");
                end

        // request and address held until the bridge takes them
        rd_held: assert property (@(posedge clk) disable iff (!resetn)
                rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
                else begin
                        failures++;
                        $error("rd_req or rd_addr changed before rd_rdy");
                end

        wr_held: assert property (@(posedge clk) disable iff (!resetn)
                wr_req && !wr_rdy |=> wr_req && $stable(wr_addr))
                else begin
                        failures++;
                        $error("wr_req or wr_addr changed before wr_rdy");
                end

        no_answer_while_waiting: assert property (@(posedge clk) disable iff (!resetn)
                (state == miss || state == replace) |-> !data_ok)
                else begin
                        failures++;
                        $error("data_ok high in miss or replace");
                end

endmodule

bind dcache_top dcache_assertions u_assertions (
        .clk(clk),
        .resetn(resetn),
        .state(state),
        .rd_req(rd_req),
        .rd_addr(rd_addr),
        .rd_rdy(rd_rdy),
        .wr_req(wr_req),
        .wr_addr(wr_addr),
        .wr_rdy(wr_rdy),
        .data_ok(data_ok)
);

/* sim/tb_dcache.sv */
`timescale 1ns/1ns
module tb_dcache;
        import dcache_pkg::*;

        localparam int max_tests = 64;
        localparam int drive_delay = 10;

        logic clk, resetn;
        logic valid, op, addr_ok, data_ok;
        index_t index;
        tag_t tag;
        offset_t offset;
        strb_t wstrb, wr_wstrb;
        word_t wdata, rdata, ret_data;
        logic rd_req, rd_rdy, ret_valid, ret_last, wr_req, wr_rdy;
        logic [2:0] rd_type, wr_type;
        addr_t rd_addr, wr_addr;
        line_t wr_data;

        word_t test_mem [max_tests * 5];        // op, addr, wstrb, wdata, expected
        int num_tests = 0;
        int responses = 0;
        int cycle = 0;
        bit exp_op [$];
        bit exp_hit [$];
        bit exp_after_write [$];
        word_t exp_word [$];
        addr_t exp_addr [$];
        int exp_cycle [$];
        addr_t resident [1 << index_bits];      // line surely cached in each set
        bit last_op = 1'b0;
        addr_t model_addr [$];                  // written words only
        word_t model_data [$];
        addr_t refill_addr;
        logic refilling;
        int beat;

        tb_clock clock_gen (.clk(clk), .resetn(resetn));

        dcache_top #(.lfsr_seed(8'h5a)) dut (.*);

        task automatic abort_run(input string why);
                $display("%s", why);
                $display("Something failed");
                $fatal(1, "run stopped");
        endtask

        task automatic check_value(input string name, input word_t got, input word_t expected);
                if (got !== expected)
                        abort_run($sformatf("error: time %0t, %s is %h, expected %h",
                                $time, name, got, expected));
        endtask

        // unwritten words hold their inverted word address
        function automatic word_t read_word(input addr_t a);
                word_t w;
                w = ~{a[31:2], 2'b00};
                foreach (model_addr[i])
                        if (model_addr[i] == {a[31:2], 2'b00})
                                w = model_data[i];
                return w;
        endfunction

        task automatic store_line(input addr_t line_addr, input line_t data);
                addr_t a;
                int slot;
                for (int b = 0; b < 4; b++) begin
                        a = {line_addr[31:4], 4'h0} + 4 * b;
                        slot = -1;
                        foreach (model_addr[i])
                                if (model_addr[i] == a)
                                        slot = i;
                        if (slot < 0) begin
                                model_addr.push_back(a);
                                model_data.push_back(data[b*32 +: 32]);
                        end else begin
                                model_data[slot] = data[b*32 +: 32];
                        end
                end
        endtask

        always @(posedge clk)
                cycle <= cycle + 1;

        always @(negedge clk)
                if (dut.u_assertions.failures != 0)
                        abort_run("a bound protocol assertion failed");

        // bridge model samples handshakes at negedge and drives after the edge
        initial begin : bridge
                logic take_rd;
                logic take_wr;
                rd_rdy = 1'b0;
                wr_rdy = 1'b0;
                ret_valid = 1'b0;
                ret_last = 1'b0;
                ret_data = '0;
                refilling = 1'b0;
                beat = 0;
                void'($urandom(67808));
                forever begin
                        @(negedge clk);
                        take_rd = rd_req && rd_rdy;
                        take_wr = wr_req && wr_rdy;
                        if (take_wr) begin
                                check_value("wr_type", wr_type, 3'b100);
                                check_value("wr_wstrb", wr_wstrb, 4'hf);
                                store_line(wr_addr, wr_data);
                        end
                        if (take_rd) begin
                                check_value("rd_type", rd_type, 3'b100);
                                refill_addr = {rd_addr[31:4], 4'h0};
                        end
                        @(posedge clk);
                        #drive_delay;
                        if (ret_valid) begin            // beat taken at this edge
                                beat = beat + 1;
                                if (beat == 4)
                                        refilling = 1'b0;
                        end
                        if (take_rd) begin
                                refilling = 1'b1;
                                beat = 0;
                        end
                        rd_rdy = ($urandom % 4) != 0;
                        wr_rdy = ($urandom % 4) != 0;
                        ret_valid = refilling && (($urandom % 4) != 0);
                        ret_last = ret_valid && beat == 3;
                        ret_data = ret_valid ? read_word(refill_addr + 4 * beat) : '0;
                end
        end

        // answers come back in order
        always @(negedge clk) begin : response_monitor
                bit r_op;
                bit r_hit;
                bit r_after_write;
                word_t r_word;
                addr_t r_addr;
                int r_cycle;
                addr_t line_addr;
                if (resetn && data_ok) begin
                        if (exp_op.size() == 0) begin
                                abort_run("data_ok came with no request outstanding");
                        end else begin
                                r_op = exp_op.pop_front();
                                r_hit = exp_hit.pop_front();
                                r_after_write = exp_after_write.pop_front();
                                r_word = exp_word.pop_front();
                                r_addr = exp_addr.pop_front();
                                r_cycle = exp_cycle.pop_front();
                                if (r_op) begin
                                        check_value("write data_ok latency", cycle - r_cycle, 1);
                                end else begin
                                        check_value($sformatf("rdata at %h", r_addr), rdata, r_word);
                                        if (r_hit)
                                                check_value("read hit data_ok latency",
                                                        cycle - r_cycle, 1);
                                        // a hit leaves lookup open to the next request
                                        if (r_hit && !r_after_write && valid)
                                                check_value("addr_ok", addr_ok, 1);
                                end
                                responses = responses + 1;
                        end
                end
                if (resetn && valid && addr_ok) begin
                        line_addr = {tag, index, 4'h0};
                        exp_word.push_back(test_mem[5 * (responses + exp_op.size()) + 4]);
                        exp_op.push_back(op);
                        exp_hit.push_back(resident[index] == line_addr);
                        exp_after_write.push_back(last_op);
                        exp_addr.push_back({tag, index, offset});
                        exp_cycle.push_back(cycle);
                        resident[index] = line_addr;
                        last_op = op;
                end
        end

        initial begin : driver
                int n;
                logic ok;
                addr_t a;
                valid = 1'b0;
                op = 1'b0;
                index = '0;
                tag = '0;
                offset = '0;
                wstrb = '0;
                wdata = '0;
                foreach (resident[i])
                        resident[i] = '1;       // matches no line address
                for (int i = 0; i < max_tests * 5; i++)
                        test_mem[i] = '1;       // end marker
                $readmemh("sim/dcache_tests.txt", test_mem);
                n = 0;
                while (n < max_tests && test_mem[5 * n] != 32'hffffffff)
                        n++;
                wait (resetn === 1'b1);
                if (n == 0)
                        abort_run("no test lines found in sim/dcache_tests.txt");
                num_tests = n;
                @(posedge clk);
                #drive_delay;
                check_value("addr_ok", addr_ok, 1);
                check_value("data_ok", data_ok, 0);
                check_value("rd_req", rd_req, 0);
                check_value("wr_req", wr_req, 0);
                for (int i = 0; i < num_tests; i++) begin
                        a = test_mem[5 * i + 1];
                        valid = 1'b1;
                        op = test_mem[5 * i][0];
                        tag = a[31:12];
                        index = a[11:4];
                        offset = a[3:0];
                        wstrb = test_mem[5 * i + 2][3:0];
                        wdata = test_mem[5 * i + 3];
                        ok = 1'b0;
                        while (!ok) begin               // hold until accepted
                                @(negedge clk);
                                ok = addr_ok;
                                @(posedge clk);
                                #drive_delay;
                        end
                end
                valid = 1'b0;
                while (exp_op.size() != 0)
                        @(posedge clk);
                repeat (4) @(posedge clk);
                if (responses != num_tests)
                        abort_run($sformatf("%0d answers for %0d requests", responses, num_tests));
                else begin
                        $display("Everything OK");
                        $finish;
                end
        end

        initial begin : watchdog
                wait (num_tests > 0);
                repeat (num_tests * 200) @(posedge clk);
                abort_run("timeout, the requests did not all complete");
        end

endmodule

/* dcache.f */
common/dcache_pkg.sv
rtl/sync_ram.sv
dcache/dcache_ctrl.sv
dcache/dcache_arrays.sv
dcache/dcache_mem_port.sv
dcache/dcache_top.sv
sim/tb_clock.sv
sim/dcache_assertions.sv
sim/tb_dcache.sv

/* sim/dcache_tests.txt */
// columns: op (0 read, 1 write), address, wstrb, wdata, expected read word; all hex
// writes carry 0 as expected word
0 00001000 0 00000000 ffffefff
0 00001000 0 00000000 ffffefff
0 00001010 0 00000000 ffffefef
0 00001024 0 00000000 ffffefdb
0 00001014 0 00000000 ffffefeb
0 00001028 0 00000000 ffffefd7
0 00001008 0 00000000 ffffeff7
0 0000102c 0 00000000 ffffefd3
1 00001004 3 12345678 00000000
0 00001004 0 00000000 ffff5678
1 0000101c c aabbccdd 00000000
0 00001028 0 00000000 ffffefd7
0 0000101c 0 00000000 aabbefe3
1 00002040 f 11111111 00000000
0 00002040 0 00000000 11111111
1 00003048 2 0000ab00 00000000
0 00003048 0 00000000 ffffabb7
0 0000304c 0 00000000 ffffcfb3
1 00004080 f 44444444 00000000
1 00005084 f 55555555 00000000
1 00006088 f 66666666 00000000
1 00007080 f 77777777 00000000
0 00004080 0 00000000 44444444
0 00005084 0 00000000 55555555
0 00006088 0 00000000 66666666
0 00007080 0 00000000 77777777
0 00004084 0 00000000 ffffbf7b
0 00002040 0 00000000 11111111
0 00001004 0 00000000 ffff5678
